// ==== logic/cachePkg.sv ====
package cachePkg;

  // Cache geometry
  localparam int numSets = 16;
  localparam int wordsPerLine = 4;
  localparam int byteBits = 2;
  localparam int indexBits = $clog2(numSets);
  localparam int offsetBits = $clog2(wordsPerLine);
  localparam int tagBits = 32 - indexBits - offsetBits - byteBits;

  // Controller state encodings
  localparam logic [2:0] stReady = 3'd0;
  localparam logic [2:0] stWriteBack = 3'd1;
  localparam logic [2:0] stMemRead = 3'd2;
  localparam logic [2:0] stNextRequest = 3'd3;
  localparam logic [2:0] stDirectWrite = 3'd4;
  localparam logic [2:0] stFlush = 3'd5;

  // Byte address, seen either whole or split into its cache fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [tagBits-1:0] tag;
      logic [indexBits-1:0] index;
      logic [offsetBits-1:0] wordOffset;
      logic [byteBits-1:0] byteOffset;
    } fields;
  } cacheAddr;

endpackage

// ==== logic/cfgPkg.sv ====
package cfgPkg;

  localparam int apbAddrBits = 8;

  // Register map
  localparam logic [apbAddrBits-1:0] regCtrl = 8'h00;
  localparam logic [apbAddrBits-1:0] regStatus = 8'h04;
  localparam logic [apbAddrBits-1:0] regHits = 8'h08;
  localparam logic [apbAddrBits-1:0] regMisses = 8'h0C;

  // CTRL fields
  localparam int ctrlEnableBit = 0;
  localparam int ctrlFlushBit = 1;

  // STATUS fields
  localparam int statusBusyBit = 0;

endpackage

// ==== logic/cacheController.sv ====
`timescale 1ns/10ps

module cacheController (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            cacheEnable,
  input  logic                            flushRequest,
  input  logic                            cpuRead,
  input  logic                            cpuWrite,
  input  cachePkg::cacheAddr              cpuAddr,
  input  logic [31:0]                     cpuWData,
  input  logic [3:0]                      cpuByteMask,
  input  logic                            hitWay1,
  input  logic                            hitWay2,
  input  logic                            lruWay,
  input  logic                            victimDirty,
  input  logic [cachePkg::tagBits-1:0]    victimTag,
  input  logic [31:0]                     readWord,
  input  logic [31:0]                     memRData,
  input  logic                            memReady,
  output logic                            stall,
  output logic [31:0]                     cpuRData,
  output logic                            memRequest,
  output logic                            memWrite,
  output logic [31:0]                     memAddr,
  output logic [31:0]                     memWData,
  output logic [cachePkg::indexBits-1:0]  lineIndex,
  output logic [cachePkg::offsetBits-1:0] wordSel,
  output logic [1:0]                      wayWrite,
  output logic                            blockWrite,
  output logic [31:0]                     writeData,
  output logic [3:0]                      writeMask,
  output logic                            dirtyIn,
  output logic                            validIn,
  output logic                            cleanIndexWay,
  output logic                            flushDone,
  output logic                            hitPulse,
  output logic                            missPulse
);
  import cachePkg::*;

  logic [2:0] state, nextState;
  logic [offsetBits-1:0] wordCount;
  // Flush walk position, set in the upper bits and way in bit 0
  logic [indexBits:0] flushCount;
  logic inFlush, replay, request, hit, fillWay;
  logic wordDone, lastWord, decide;
  logic [31:0] bypassWord;
  cacheAddr lineAddr;

  assign request = cpuRead | cpuWrite;
  assign hit = hitWay1 | hitWay2;
  assign wordDone = memRequest & memReady;
  assign lastWord = wordDone & (wordCount == offsetBits'(wordsPerLine - 1));

  // Hitting way first, else the replacement way from storage
  assign fillWay = hitWay2 | (~hitWay1 & lruWay);
  assign cleanIndexWay = inFlush ? flushCount[0] : fillWay;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= stReady;
    end else begin
      state <= nextState;
    end
  end

  // Word counter for line transfers, held while memReady is low
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      wordCount <= '0;
    end else if (state == stReady || state == stNextRequest || state == stFlush) begin
      wordCount <= '0;
    end else if (wordDone) begin
      wordCount <= wordCount + 1'b1;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      flushCount <= '0;
      inFlush <= 1'b0;
      replay <= 1'b0;
    end else begin
      // Access was already resolved by memory, the next ready cycle completes it
      replay <= (state == stNextRequest);
      if (state == stReady && flushRequest) begin
        inFlush <= 1'b1;
      end else if (flushDone) begin
        inFlush <= 1'b0;
      end
      if (state == stFlush && !victimDirty) begin
        flushCount <= flushCount + 1'b1;
      end
    end
  end

  // Word returned by an uncached read
  always_ff @(posedge clk) begin
    if (state == stMemRead && wordDone && !cacheEnable) begin
      bypassWord <= memRData;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      stReady: begin
        if (flushRequest) begin
          nextState = stFlush;
        end else if (request && !cacheEnable && !replay) begin
          nextState = cpuWrite ? stDirectWrite : stMemRead;
        end else if (request && cacheEnable && !hit) begin
          nextState = victimDirty ? stWriteBack : stMemRead;
        end
      end
      stWriteBack: begin
        if (lastWord) begin
          nextState = inFlush ? stFlush : stMemRead;
        end
      end
      stMemRead: begin
        if (lastWord || (wordDone && !cacheEnable)) begin
          nextState = stNextRequest;
        end
      end
      stDirectWrite: begin
        if (wordDone) begin
          nextState = stNextRequest;
        end
      end
      stNextRequest: nextState = stReady;
      stFlush: begin
        if (victimDirty) begin
          nextState = stWriteBack;
        end else if (&flushCount) begin
          nextState = stReady;
        end
      end
      default: nextState = stReady;
    endcase
  end

  assign stall = (state != stReady) | flushRequest |
                 (request & (cacheEnable ? ~hit : ~replay));
  assign cpuRData = cacheEnable ? readWord : bypassWord;

  assign memRequest = (state == stWriteBack) | (state == stMemRead) |
                      (state == stDirectWrite);
  assign memWrite = (state == stWriteBack) | (state == stDirectWrite);
  assign memWData = (state == stWriteBack) ? readWord : cpuWData;

  assign lineIndex = inFlush ? flushCount[indexBits:1] : cpuAddr.fields.index;
  assign wordSel = (state == stWriteBack || state == stMemRead) ?
                   wordCount : cpuAddr.fields.wordOffset;

  // Victim tag on write-back, request tag on fill, request word when uncached
  always_comb begin
    lineAddr = cpuAddr;
    lineAddr.fields.byteOffset = '0;
    if (state == stWriteBack) begin
      lineAddr.fields.tag = victimTag;
      lineAddr.fields.index = lineIndex;
      lineAddr.fields.wordOffset = wordCount;
    end else if (cacheEnable) begin
      lineAddr.fields.wordOffset = wordCount;
    end
    memAddr = lineAddr.raw;
  end

  // Storage write port
  always_comb begin
    wayWrite = 2'b00;
    blockWrite = 1'b0;
    writeData = cpuWData;
    writeMask = 4'b0000;
    dirtyIn = cpuWrite;
    case (state)
      stReady: begin
        // Read hits touch the way only for LRU
        if (cacheEnable && request && hit && !flushRequest) begin
          wayWrite = {cleanIndexWay, ~cleanIndexWay};
          writeMask = cpuWrite ? cpuByteMask : 4'b0000;
        end
      end
      stMemRead: begin
        if (cacheEnable && wordDone) begin
          wayWrite = {cleanIndexWay, ~cleanIndexWay};
          blockWrite = 1'b1;
          writeMask = 4'b1111;
          // Pending store bytes go in with the fill word they belong to
          for (int b = 0; b < 4; b++) begin
            if (!(cpuWrite && cpuByteMask[b] && wordCount == cpuAddr.fields.wordOffset)) begin
              writeData[8*b +: 8] = memRData[8*b +: 8];
            end
          end
        end
      end
      stWriteBack: begin
        // Flushed line becomes clean, tag and data stay
        if (inFlush && lastWord) begin
          wayWrite = {cleanIndexWay, ~cleanIndexWay};
          blockWrite = 1'b1;
          dirtyIn = 1'b0;
        end
      end
      default: begin
        wayWrite = 2'b00;
      end
    endcase
  end

  // lines are never invalidated after reset
  assign validIn = 1'b1;

  assign decide = (state == stReady) & ~flushRequest & request & cacheEnable & ~replay;
  assign hitPulse = decide & hit;
  assign missPulse = decide & ~hit;
  assign flushDone = (state == stFlush) & ~victimDirty & (&flushCount);

endmodule

// ==== logic/cacheWays.sv ====
`timescale 1ns/10ps

module cacheWays (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cachePkg::indexBits-1:0]  lineIndex,
  input  logic [cachePkg::offsetBits-1:0] wordSel,
  input  logic [cachePkg::tagBits-1:0]    tag,
  input  logic [1:0]                      wayWrite,
  input  logic                            blockWrite,
  input  logic [31:0]                     writeData,
  input  logic [3:0]                      writeMask,
  input  logic                            dirtyIn,
  input  logic                            validIn,
  input  logic                            cleanIndexWay,
  output logic                            hitWay1,
  output logic                            hitWay2,
  output logic                            lruWay,
  output logic                            victimDirty,
  output logic [cachePkg::tagBits-1:0]    victimTag,
  output logic [31:0]                     readWord
);
  import cachePkg::*;

  logic [31:0] dataArr [2][numSets][wordsPerLine];
  logic [tagBits-1:0] tagArr [2][numSets];
  logic [numSets-1:0] validBits [2];
  logic [numSets-1:0] dirtyBits [2];
  // Per set, the way used least recently
  logic [numSets-1:0] lruBits;
  logic [1:0] lineValid;
  logic touch;

  assign lineValid[0] = validBits[0][lineIndex];
  assign lineValid[1] = validBits[1][lineIndex];

  assign hitWay1 = lineValid[0] & (tagArr[0][lineIndex] == tag);
  assign hitWay2 = lineValid[1] & (tagArr[1][lineIndex] == tag);

  // Empty way wins over the LRU way
  assign lruWay = !lineValid[0] ? 1'b0 : (!lineValid[1] ? 1'b1 : lruBits[lineIndex]);

  assign victimTag = tagArr[cleanIndexWay][lineIndex];
  assign victimDirty = validBits[cleanIndexWay][lineIndex] &
                       dirtyBits[cleanIndexWay][lineIndex];
  assign readWord = dataArr[cleanIndexWay][lineIndex][wordSel];

  // A state-only block write (flush clean) leaves LRU alone
  assign touch = (|wayWrite) & (~blockWrite | (|writeMask));

  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (wayWrite[w] && blockWrite && |writeMask) begin
        tagArr[w][lineIndex] <= tag;
      end
      for (int b = 0; b < 4; b++) begin
        if (wayWrite[w] && writeMask[b]) begin
          dataArr[w][lineIndex][wordSel][8*b +: 8] <= writeData[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits <= '{default: '0};
      dirtyBits <= '{default: '0};
      lruBits <= '0;
    end else begin
      for (int w = 0; w < 2; w++) begin
        if (wayWrite[w] && blockWrite) begin
          validBits[w][lineIndex] <= validIn;
          dirtyBits[w][lineIndex] <= dirtyIn;
        end else if (wayWrite[w] && |writeMask) begin
          dirtyBits[w][lineIndex] <= dirtyIn;
        end
      end
      // The way not touched becomes LRU
      if (touch) begin
        lruBits[lineIndex] <= wayWrite[0];
      end
    end
  end

endmodule

// ==== logic/cacheConfig.sv ====
`timescale 1ns/10ps

module cacheConfig (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [cfgPkg::apbAddrBits-1:0] paddr,
  input  logic [31:0]                    pwdata,
  input  logic                           flushDone,
  input  logic                           hitPulse,
  input  logic                           missPulse,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic                           cacheEnable,
  output logic                           flushRequest
);
  import cfgPkg::*;

  logic [31:0] hitCount, missCount;
  logic apbWrite, mapped;

  assign apbWrite = psel & penable & pwrite;
  assign mapped = paddr inside {regCtrl, regStatus, regHits, regMisses};

  // No wait states
  assign pready = 1'b1;
  assign pslverr = psel & penable & ~mapped;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      cacheEnable <= 1'b0;
      flushRequest <= 1'b0;
      hitCount <= '0;
      missCount <= '0;
    end else begin
      if (apbWrite && paddr == regCtrl) begin
        cacheEnable <= pwdata[ctrlEnableBit];
      end
      // Flush bit stays set until the controller reports it done
      if (apbWrite && paddr == regCtrl && pwdata[ctrlFlushBit]) begin
        flushRequest <= 1'b1;
      end else if (flushDone) begin
        flushRequest <= 1'b0;
      end
      if (apbWrite && paddr == regHits) begin
        hitCount <= '0;
      end else if (hitPulse) begin
        hitCount <= hitCount + 1'b1;
      end
      if (apbWrite && paddr == regMisses) begin
        missCount <= '0;
      end else if (missPulse) begin
        missCount <= missCount + 1'b1;
      end
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      regCtrl: begin
        prdata[ctrlEnableBit] = cacheEnable;
        prdata[ctrlFlushBit] = flushRequest;
      end
      regStatus: prdata[statusBusyBit] = flushRequest;
      regHits: prdata = hitCount;
      regMisses: prdata = missCount;
      default: prdata = '0;
    endcase
  end

endmodule

// ==== logic/dataCache.sv ====
`timescale 1ns/10ps

module dataCache (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           cpuRead,
  input  logic                           cpuWrite,
  input  logic [31:0]                    cpuAddr,
  input  logic [31:0]                    cpuWData,
  input  logic [3:0]                     cpuByteMask,
  input  logic [31:0]                    memRData,
  input  logic                           memReady,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [cfgPkg::apbAddrBits-1:0] paddr,
  input  logic [31:0]                    pwdata,
  output logic [31:0]                    cpuRData,
  output logic                           stall,
  output logic                           memRequest,
  output logic                           memWrite,
  output logic [31:0]                    memAddr,
  output logic [31:0]                    memWData,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr
);
  import cachePkg::*;

  // Configuration handshake
  logic cacheEnable, flushRequest, flushDone, hitPulse, missPulse;

  // Storage lookup and write port
  logic hitWay1, hitWay2, lruWay, victimDirty;
  logic [tagBits-1:0] victimTag;
  logic [31:0] readWord, writeData;
  logic [indexBits-1:0] lineIndex;
  logic [offsetBits-1:0] wordSel;
  logic [1:0] wayWrite;
  logic [3:0] writeMask;
  logic blockWrite, dirtyIn, validIn, cleanIndexWay;

  cacheController controller (
    .clk(clk), .reset(reset),
    .cacheEnable(cacheEnable), .flushRequest(flushRequest),
    .cpuRead(cpuRead), .cpuWrite(cpuWrite), .cpuAddr(cpuAddr),
    .cpuWData(cpuWData), .cpuByteMask(cpuByteMask),
    .hitWay1(hitWay1), .hitWay2(hitWay2), .lruWay(lruWay),
    .victimDirty(victimDirty), .victimTag(victimTag), .readWord(readWord),
    .memRData(memRData), .memReady(memReady),
    .stall(stall), .cpuRData(cpuRData),
    .memRequest(memRequest), .memWrite(memWrite),
    .memAddr(memAddr), .memWData(memWData),
    .lineIndex(lineIndex), .wordSel(wordSel), .wayWrite(wayWrite),
    .blockWrite(blockWrite), .writeData(writeData), .writeMask(writeMask),
    .dirtyIn(dirtyIn), .validIn(validIn), .cleanIndexWay(cleanIndexWay),
    .flushDone(flushDone), .hitPulse(hitPulse), .missPulse(missPulse)
  );

  cacheWays ways (
    .clk(clk), .reset(reset),
    .lineIndex(lineIndex), .wordSel(wordSel),
    .tag(cpuAddr[31 -: tagBits]),
    .wayWrite(wayWrite), .blockWrite(blockWrite),
    .writeData(writeData), .writeMask(writeMask),
    .dirtyIn(dirtyIn), .validIn(validIn), .cleanIndexWay(cleanIndexWay),
    .hitWay1(hitWay1), .hitWay2(hitWay2), .lruWay(lruWay),
    .victimDirty(victimDirty), .victimTag(victimTag), .readWord(readWord)
  );

  cacheConfig config0 (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .flushDone(flushDone), .hitPulse(hitPulse), .missPulse(missPulse),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .cacheEnable(cacheEnable), .flushRequest(flushRequest)
  );

endmodule

// ==== bench/dataCache_props.sv ====
`timescale 1ns/10ps

module dataCacheProps (
  input logic clk,
  input logic reset,
  input logic cpuRead,
  input logic cpuWrite,
  input logic stall,
  input logic memRequest,
  input logic memWrite,
  input logic pready,
  input logic flushRequest,
  input logic flushDone
);

  // A memory write is always part of a request
  writeInRequest: assert property (@(posedge clk) disable iff (reset) memWrite |-> memRequest)
    else $error("memWrite high while memRequest is low");

  // APB never inserts wait states
  noWaitStates: assert property (@(posedge clk) pready)
    else $error("pready dropped low");

  // First cycle out of reset with no request
  idleAfterReset: assert property (@(posedge clk)
    (!reset && $past(reset) && !cpuRead && !cpuWrite) |-> !stall)
    else $error("stall high right after reset with no request");

  flushDoneRequested: assert property (@(posedge clk) disable iff (reset)
    flushDone |-> flushRequest)
    else $error("flushDone high while flushRequest is low");

endmodule

bind dataCache dataCacheProps props (
  .clk(clk), .reset(reset), .cpuRead(cpuRead), .cpuWrite(cpuWrite),
  .stall(stall), .memRequest(memRequest), .memWrite(memWrite), .pready(pready),
  .flushRequest(flushRequest), .flushDone(flushDone)
);

// ==== bench/dataCacheTb.sv ====
`timescale 1ns/10ps

module dataCacheTb;
  import cachePkg::*;
  import cfgPkg::*;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic cpuRead = 1'b0;
  logic cpuWrite = 1'b0;
  logic [31:0] cpuAddr = '0;
  logic [31:0] cpuWData = '0;
  logic [3:0] cpuByteMask = '0;
  logic [31:0] memRData = '0;
  logic memReady = 1'b0;
  logic psel = 1'b0;
  logic penable = 1'b0;
  logic pwrite = 1'b0;
  logic [apbAddrBits-1:0] paddr = '0;
  logic [31:0] pwdata = '0;
  logic [31:0] cpuRData, memAddr, memWData, prdata;
  logic stall, memRequest, memWrite, pready, pslverr;

  // Memory model contents and the expected value of every word
  logic [31:0] memory [1024];
  logic [31:0] shadow [1024];
  logic [31:0] writtenAddrs [$];
  integer seed = 32'h2f3a;
  int writeBeats = 0;

  // Reference tags and LRU per set
  logic [tagBits-1:0] refTag [2][numSets];
  logic refValid [2][numSets];
  logic refLru [numSets];
  logic cacheOn = 1'b0;
  int hitCount = 0;
  int missCount = 0;

  dataCache uut (
    .clk(clk), .reset(reset),
    .cpuRead(cpuRead), .cpuWrite(cpuWrite), .cpuAddr(cpuAddr),
    .cpuWData(cpuWData), .cpuByteMask(cpuByteMask),
    .memRData(memRData), .memReady(memReady),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .cpuRData(cpuRData), .stall(stall),
    .memRequest(memRequest), .memWrite(memWrite), .memAddr(memAddr), .memWData(memWData),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  always #4 clk = ~clk;

  // Initial word depends on the whole word address
  function automatic logic [31:0] fillWord(input int idx);
    return (32'(idx) * 32'h0100_0193) ^ 32'ha5c3_0f1e;
  endfunction

  function automatic logic [31:0] makeAddr(input int tag, input int set, input int word);
    cacheAddr a;
    a.raw = '0;
    a.fields.tag = tagBits'(tag);
    a.fields.index = indexBits'(set);
    a.fields.wordOffset = offsetBits'(word);
    return a.raw;
  endfunction

  // Memory answers a held request after a random number of wait cycles
  initial begin
    for (int i = 0; i < 1024; i++) begin
      memory[i] = fillWord(i);
    end
    forever begin
      @(posedge clk);
      if (memRequest && memReady) begin
        if (memWrite) begin
          memory[memAddr[11:2]] <= memWData;
          writeBeats <= writeBeats + 1;
        end
        memReady <= 1'b0;
      end else if (memRequest && ($random(seed) & 3) != 0) begin
        memRData <= memory[memAddr[11:2]];
        memReady <= 1'b1;
      end
    end
  end

  task automatic stopWithFailure();
    $display("** FAIL **");
    $fatal(1, "Stopped at the first error");
  endtask

  // Empty way first, else LRU, and the other way becomes LRU
  task automatic trackAccess(input cacheAddr a, output logic hit);
    logic [indexBits-1:0] s;
    logic w;
    s = a.fields.index;
    hit = 1'b0;
    w = !refValid[0][s] ? 1'b0 : (!refValid[1][s] ? 1'b1 : refLru[s]);
    for (int i = 0; i < 2; i++) begin
      if (refValid[i][s] && refTag[i][s] == a.fields.tag) begin
        hit = 1'b1;
        w = i[0];
      end
    end
    refValid[w][s] = 1'b1;
    refTag[w][s] = a.fields.tag;
    refLru[s] = ~w;
    if (hit) hitCount++;
    else missCount++;
  endtask

  task automatic cpuAccess(input logic isWrite, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] mask, output logic [31:0] rdata,
                           output logic stalled);
    int waitCycles;
    @(posedge clk);
    cpuRead <= ~isWrite;
    cpuWrite <= isWrite;
    cpuAddr <= addr;
    cpuWData <= data;
    cpuByteMask <= mask;
    @(negedge clk);
    stalled = stall;
    waitCycles = 0;
    while (stall) begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles > 200) begin
        $display("Processor access to %h never completed, stall stayed high", addr);
        stopWithFailure();
      end
    end
    rdata = cpuRData;
    @(posedge clk);
    cpuRead <= 1'b0;
    cpuWrite <= 1'b0;
  endtask

  task automatic readCheck(input logic [31:0] addr);
    cacheAddr a;
    logic expectHit, stalled;
    logic [31:0] rdata;
    a.raw = addr;
    expectHit = 1'b0;
    if (cacheOn) trackAccess(a, expectHit);
    cpuAccess(1'b0, addr, '0, 4'h0, rdata, stalled);
    assert (rdata == shadow[addr[11:2]]) else begin
      $display("** Error cpuRData at %h: got %h, expected %h", addr, rdata, shadow[addr[11:2]]);
      stopWithFailure();
    end
    assert (!cacheOn || stalled == !expectHit) else begin
      $display("** Error stall at %h in request cycle: got %h, expected %h",
               addr, stalled, !expectHit);
      stopWithFailure();
    end
  endtask

  task automatic writeWord(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] mask);
    cacheAddr a;
    logic expectHit, stalled;
    logic [31:0] rdata;
    a.raw = addr;
    if (cacheOn) trackAccess(a, expectHit);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) shadow[addr[11:2]][8*b +: 8] = data[8*b +: 8];
    end
    writtenAddrs.push_back(addr);
    cpuAccess(1'b1, addr, data, mask, rdata, stalled);
  endtask

  task automatic checkMemory(input logic [31:0] addr);
    assert (memory[addr[11:2]] == shadow[addr[11:2]]) else begin
      $display("** Error memory[%h]: got %h, expected %h",
               addr, memory[addr[11:2]], shadow[addr[11:2]]);
      stopWithFailure();
    end
  endtask

  task automatic waitReady();
    int waitCycles;
    waitCycles = 0;
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles > 20) begin
        $display("APB transfer never completed, pready stayed low");
        stopWithFailure();
      end
    end
  endtask

  task automatic apbWriteReg(input logic [apbAddrBits-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel <= 1'b1;
    pwrite <= 1'b1;
    paddr <= addr;
    pwdata <= data;
    @(posedge clk);
    penable <= 1'b1;
    waitReady();
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apbReadReg(input logic [apbAddrBits-1:0] addr, output logic [31:0] data,
                            output logic err);
    @(posedge clk);
    psel <= 1'b1;
    pwrite <= 1'b0;
    paddr <= addr;
    @(posedge clk);
    penable <= 1'b1;
    waitReady();
    data = prdata;
    err = pslverr;
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  initial begin
    logic [31:0] value;
    logic err;
    int beats;
    int polls;
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = fillWord(i);
    end
    for (int s = 0; s < numSets; s++) begin
      refValid[0][s] = 1'b0;
      refValid[1][s] = 1'b0;
      refLru[s] = 1'b0;
    end
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // Uncached accesses go straight to memory
    beats = writeBeats;
    writeWord(32'h0000_0040, 32'hdead_beef, 4'hf);
    assert (writeBeats == beats + 1) else begin
      $display("Uncached write did not reach memory as exactly one word");
      stopWithFailure();
    end
    checkMemory(32'h0000_0040);
    readCheck(32'h0000_0044);
    readCheck(32'h0000_0040);

    // Line fill, hits and a byte-masked store
    apbWriteReg(regCtrl, 32'h1 << ctrlEnableBit);
    cacheOn = 1'b1;
    readCheck(32'h0000_0120);
    readCheck(32'h0000_0124);
    readCheck(32'h0000_012c);
    writeWord(32'h0000_0128, 32'h1122_3344, 4'b0101);
    readCheck(32'h0000_0128);
    writeWord(32'h0000_0044, 32'h5566_7788, 4'b1000);
    readCheck(32'h0000_0044);

    // Three dirty lines in set 5 force a write-back of the oldest
    writeWord(makeAddr(1, 5, 2), 32'hc001_0001, 4'hf);
    writeWord(makeAddr(2, 5, 1), 32'hc002_0002, 4'hf);
    writeWord(makeAddr(3, 5, 3), 32'hc003_0003, 4'hf);
    for (int w = 0; w < wordsPerLine; w++) begin
      checkMemory(makeAddr(1, 5, w));
    end
    readCheck(makeAddr(2, 5, 1));
    readCheck(makeAddr(3, 5, 3));
    readCheck(makeAddr(1, 5, 2));

    // Flush all dirty lines and poll STATUS
    apbWriteReg(regCtrl, (32'h1 << ctrlEnableBit) | (32'h1 << ctrlFlushBit));
    apbReadReg(regStatus, value, err);
    assert (value[statusBusyBit]) else begin
      $display("** Error prdata STATUS after flush start: got %h, expected busy", value);
      stopWithFailure();
    end
    polls = 0;
    while (value[statusBusyBit]) begin
      polls++;
      if (polls > 200) begin
        $display("Flush never finished, STATUS stayed busy");
        stopWithFailure();
      end
      apbReadReg(regStatus, value, err);
    end
    foreach (writtenAddrs[i]) checkMemory(writtenAddrs[i]);
    readCheck(makeAddr(3, 5, 3));
    readCheck(32'h0000_0128);
    readCheck(32'h0000_0044);

    // Counters and an unmapped register
    apbReadReg(regHits, value, err);
    assert (value == 32'(hitCount)) else begin
      $display("** Error prdata HITS: got %h, expected %h", value, hitCount);
      stopWithFailure();
    end
    apbReadReg(regMisses, value, err);
    assert (value == 32'(missCount)) else begin
      $display("** Error prdata MISSES: got %h, expected %h", value, missCount);
      stopWithFailure();
    end
    apbReadReg(8'h10, value, err);
    assert (err) else begin
      $display("** Error pslverr at 10: got %h, expected 1", err);
      stopWithFailure();
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== project.f ====
logic/cachePkg.sv
logic/cfgPkg.sv
logic/cacheController.sv
logic/cacheWays.sv
logic/cacheConfig.sv
logic/dataCache.sv
bench/dataCache_props.sv
bench/dataCacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module dataCacheTb \
  -f project.f \
  -Mdir obj_dir \
  -o dataCacheSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dataCacheSim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi
exit 0
